//--- verilog/ppu_reg_pkg.sv
`default_nettype none

package ppu_reg_pkg;

    typedef logic [2:0] cpu_addr_t;   // register select
    typedef logic [7:0] cpu_data_t;

    // OAM addresses 3 and 4 are not decoded
    localparam cpu_addr_t PPUCTRL_ADDR   = 3'd0;
    localparam cpu_addr_t PPUMASK_ADDR   = 3'd1;
    localparam cpu_addr_t PPUSTATUS_ADDR = 3'd2;
    localparam cpu_addr_t PPUSCROLL_ADDR = 3'd5;
    localparam cpu_addr_t PPUADDR_ADDR   = 3'd6;
    localparam cpu_addr_t PPUDATA_ADDR   = 3'd7;

    // PPUCTRL bits
    localparam int CTRL_INC32    = 2;   // data port step of 32
    localparam int CTRL_BG_TABLE = 4;   // pattern table for background
    localparam int CTRL_NMI_EN   = 7;

    // PPUMASK bits
    localparam int MASK_BG_EN = 3;

    typedef struct packed {
        logic       bg_en;
        logic       bg_table;
        logic [2:0] fine_x;
    } ppu_render_cfg_t;

    // address commands from the CPU side
    typedef struct packed {
        logic        load;   // copy t into v
        logic        inc;
        logic        inc32;
        logic [14:0] t;      // yyy NN YYYYY XXXXX
    } ppu_vaddr_cmd_t;

endpackage

`default_nettype wire

//--- verilog/ppu_video_pkg.sv
`default_nettype none

package ppu_video_pkg;

    typedef logic [14:0] vaddr_t;       // fine y, nametable, coarse y, coarse x
    typedef logic [13:0] vram_addr_t;
    typedef logic [4:0]  pal_idx_t;
    typedef logic [7:0]  color_t;

    // frame timing
    localparam int DOTS_PER_LINE   = 341;
    localparam int LINES_PER_FRAME = 262;
    localparam int VISIBLE_DOTS    = 256;
    localparam int VISIBLE_LINES   = 240;
    localparam int VBLANK_LINE     = 241;

    // scroll updates requested by the renderer
    typedef struct packed {
        logic incx;
        logic incy;
        logic resetx;
        logic resety;
    } ppu_scroll_ctl_t;

    typedef struct packed {
        logic        tile;
        logic        attr;
        logic        chr;
        logic [12:0] pattern_addr;
    } ppu_fetch_t;

    typedef enum logic [1:0] {
        FETCH_NT,
        FETCH_AT,
        FETCH_LO,
        FETCH_HI
    } bg_state_e;

endpackage

`default_nettype wire

//--- verilog/ppu_cpu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_cpu_regs
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            cs_i,
    input  logic            cpu_rw_i,
    input  cpu_addr_t       cpu_addr_i,
    input  cpu_data_t       cpu_data_i,
    input  cpu_data_t       vram_data_i,
    input  color_t          pal_data_i,
    input  logic            vpal_i,
    input  logic            vblank_i,
    output cpu_data_t       cpu_data_o,
    output ppu_render_cfg_t cfg_o,
    output ppu_vaddr_cmd_t  vcmd_o,
    output logic            vram_wr_o,
    output logic            pal_wr_o,
    output cpu_data_t       wdata_o,
    output logic            nmi_o
);

    logic        cs_q;
    logic        rd_stb;
    logic        wr_stb;
    cpu_data_t   ctrl_q;
    cpu_data_t   mask_q;
    cpu_data_t   bus_q;       // latched I/O bus
    cpu_data_t   rd_buf_q;
    cpu_data_t   status;
    logic [14:0] t_q;
    logic [2:0]  fine_x_q;
    logic        w_q;         // first/second write toggle
    logic        load_q;
    logic        inc_q;
    logic        fill_q;      // read buffer captures vram data
    logic        vram_wr_q;
    logic        pal_wr_q;
    logic        vblank_q;
    logic        nmi_flag_q;
    logic        vblank_rise;
    logic        vblank_fall;

    // access starts on the first cycle of cs high
    assign rd_stb = cs_i & ~cs_q & cpu_rw_i;
    assign wr_stb = cs_i & ~cs_q & ~cpu_rw_i;

    assign vblank_rise = vblank_i & ~vblank_q;
    assign vblank_fall = ~vblank_i & vblank_q;

    // bits 6:0 come back as whatever sits on the bus
    assign status = {nmi_flag_q | vblank_rise, bus_q[6:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q       <= 1'b0;
            ctrl_q     <= '0;
            mask_q     <= '0;
            bus_q      <= '0;
            rd_buf_q   <= '0;
            t_q        <= '0;
            fine_x_q   <= '0;
            w_q        <= 1'b0;
            load_q     <= 1'b0;
            inc_q      <= 1'b0;
            fill_q     <= 1'b0;
            vram_wr_q  <= 1'b0;
            pal_wr_q   <= 1'b0;
            vblank_q   <= 1'b0;
            nmi_flag_q <= 1'b0;
        end else begin
            cs_q       <= cs_i;
            vblank_q   <= vblank_i;
            nmi_flag_q <= (nmi_flag_q | vblank_rise) & ~vblank_fall;
            load_q     <= 1'b0;
            inc_q      <= 1'b0;
            fill_q     <= 1'b0;
            vram_wr_q  <= 1'b0;
            pal_wr_q   <= 1'b0;

            if (fill_q) rd_buf_q <= vram_data_i;   // address not yet stepped

            if (rd_stb) begin
                case (cpu_addr_i)
                    PPUSTATUS_ADDR: begin
                        bus_q      <= status;
                        nmi_flag_q <= 1'b0;
                        w_q        <= 1'b0;
                    end
                    PPUDATA_ADDR: begin
                        bus_q  <= vpal_i ? pal_data_i : rd_buf_q;
                        fill_q <= 1'b1;
                        inc_q  <= 1'b1;
                    end
                    default: ;
                endcase
            end

            if (wr_stb) begin
                bus_q <= cpu_data_i;
                case (cpu_addr_i)
                    PPUCTRL_ADDR: begin
                        ctrl_q     <= cpu_data_i;
                        t_q[11:10] <= cpu_data_i[1:0];   // nametable select
                    end
                    PPUMASK_ADDR: mask_q <= cpu_data_i;
                    PPUSCROLL_ADDR: begin
                        if (!w_q) begin
                            t_q[4:0] <= cpu_data_i[7:3];
                            fine_x_q <= cpu_data_i[2:0];
                        end else begin
                            t_q[9:5]   <= cpu_data_i[7:3];
                            t_q[14:12] <= cpu_data_i[2:0];
                        end
                        w_q <= ~w_q;
                    end
                    PPUADDR_ADDR: begin
                        if (!w_q) begin
                            t_q[14:8] <= {1'b0, cpu_data_i[5:0]};   // high byte
                        end else begin
                            t_q[7:0] <= cpu_data_i;
                            load_q   <= 1'b1;
                        end
                        w_q <= ~w_q;
                    end
                    PPUDATA_ADDR: begin
                        vram_wr_q <= ~vpal_i;
                        pal_wr_q  <= vpal_i;
                        inc_q     <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cpu_data_o = bus_q;
    assign wdata_o    = bus_q;
    assign vram_wr_o  = vram_wr_q;
    assign pal_wr_o   = pal_wr_q;
    assign nmi_o      = nmi_flag_q & ctrl_q[CTRL_NMI_EN];

    assign cfg_o.bg_en    = mask_q[MASK_BG_EN];
    assign cfg_o.bg_table = ctrl_q[CTRL_BG_TABLE];
    assign cfg_o.fine_x   = fine_x_q;

    assign vcmd_o.load  = load_q;
    assign vcmd_o.inc   = inc_q;
    assign vcmd_o.inc32 = ctrl_q[CTRL_INC32];
    assign vcmd_o.t     = t_q;

endmodule

`default_nettype wire

//--- verilog/ppu_vram_addr.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_vram_addr
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  ppu_vaddr_cmd_t  vcmd_i,
    input  ppu_scroll_ctl_t scroll_i,
    input  ppu_fetch_t      fetch_i,
    output vaddr_t          v_o,
    output vram_addr_t      vram_addr_o,
    output logic            vpal_o
);

    vaddr_t     v_q;
    vaddr_t     v_next;
    vram_addr_t attr_addr;

    always_comb begin
        v_next = v_q;
        if (vcmd_i.load) begin
            v_next = vcmd_i.t;
        end else if (vcmd_i.inc) begin
            v_next = v_q + (vcmd_i.inc32 ? 15'd32 : 15'd1);
        end else begin
            if (scroll_i.incx) begin
                if (v_q[4:0] == 5'd31) begin
                    v_next[10] = ~v_q[10];          // into the next nametable
                end
                v_next[4:0] = v_q[4:0] + 5'd1;
            end
            if (scroll_i.incy) begin
                if (v_q[14:12] == 3'd7) begin
                    if (v_q[9:5] == 5'd29) begin
                        v_next[9:5] = 5'd0;
                        v_next[11]  = ~v_q[11];
                    end else begin
                        v_next[9:5] = v_q[9:5] + 5'd1;   // 31 wraps without a flip
                    end
                end
                v_next[14:12] = v_q[14:12] + 3'd1;
            end
            if (scroll_i.resetx) begin
                v_next[10]  = vcmd_i.t[10];
                v_next[4:0] = vcmd_i.t[4:0];
            end
            if (scroll_i.resety) begin
                v_next[14:11] = vcmd_i.t[14:11];
                v_next[9:5]   = vcmd_i.t[9:5];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_q <= '0;
        end else begin
            v_q <= v_next;
        end
    end

    // attribute byte for the 32x32 block holding the current tile
    assign attr_addr = {2'b10, v_q[11:10], 4'b1111, v_q[9:7], v_q[4:2]};

    always_comb begin
        if (fetch_i.attr) begin
            vram_addr_o = attr_addr;
        end else if (fetch_i.chr) begin
            vram_addr_o = {1'b0, fetch_i.pattern_addr};
        end else if (fetch_i.tile) begin
            vram_addr_o = {2'b10, v_q[11:0]};
        end else begin
            vram_addr_o = v_q[13:0];         // CPU data port
        end
    end

    assign vpal_o = (v_q[13:8] == 6'h3F);
    assign v_o    = v_q;

endmodule

`default_nettype wire

//--- verilog/ppu_bg_render.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_bg_render
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
#(
    parameter bit external_frame_trigger = 1'b0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            trigger_frame_i,
    input  ppu_render_cfg_t cfg_i,
    input  vaddr_t          v_i,
    input  cpu_data_t       data_i,
    output ppu_fetch_t      fetch_o,
    output ppu_scroll_ctl_t scroll_o,
    output pal_idx_t        palette_idx_o,
    output logic            px_en_o,
    output logic            vblank_o
);

    localparam logic [8:0] LAST_DOT  = 9'(DOTS_PER_LINE - 1);
    localparam logic [8:0] PRE_LINE  = 9'(LINES_PER_FRAME - 1);
    localparam logic [8:0] VIS_DOTS  = 9'(VISIBLE_DOTS);
    localparam logic [8:0] VIS_LINES = 9'(VISIBLE_LINES);
    localparam logic [8:0] VBL_LINE  = 9'(VBLANK_LINE);

    logic [8:0]  dot_q;
    logic [8:0]  line_q;
    logic        hold;
    logic        render_line;
    logic        fetch_win;
    logic        prefetch;
    bg_state_e   state_q;
    bg_state_e   state_next;
    cpu_data_t   nt_q;
    cpu_data_t   lo_q;
    logic [1:0]  at_q;
    logic [15:0] pat_lo_q;
    logic [15:0] pat_hi_q;
    logic [15:0] at_lo_q;
    logic [15:0] at_hi_q;
    logic [3:0]  bit_sel;
    logic [1:0]  pix;
    logic [1:0]  pal_grp;

    // in trigger mode the frame waits at its origin
    assign hold = external_frame_trigger && dot_q == '0 && line_q == '0 && !trigger_frame_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            dot_q  <= '0;
            line_q <= '0;
        end else if (!hold) begin
            if (dot_q == LAST_DOT) begin
                dot_q  <= '0;
                line_q <= (line_q == PRE_LINE) ? '0 : line_q + 9'd1;
            end else begin
                dot_q <= dot_q + 9'd1;
            end
        end
    end

    assign render_line = (line_q < VIS_LINES) || (line_q == PRE_LINE);
    assign prefetch    = (dot_q >= 9'd321) && (dot_q <= 9'd336);   // first two tiles of next line
    assign fetch_win   = cfg_i.bg_en && render_line &&
                         (((dot_q >= 9'd1) && (dot_q <= VIS_DOTS)) || prefetch);

    // state steps on even dots with two dots per fetch
    always_comb begin
        case (state_q)
            FETCH_NT: state_next = FETCH_AT;
            FETCH_AT: state_next = FETCH_LO;
            FETCH_LO: state_next = FETCH_HI;
            default:  state_next = FETCH_NT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !fetch_win) begin
            state_q <= FETCH_NT;
        end else if (!dot_q[0]) begin
            state_q <= state_next;
        end
    end

    // shifters run every fetch dot and reload their low byte on the high fetch
    always_ff @(posedge clk) begin
        if (fetch_win) begin
            pat_lo_q <= pat_lo_q << 1;
            pat_hi_q <= pat_hi_q << 1;
            at_lo_q  <= at_lo_q << 1;
            at_hi_q  <= at_hi_q << 1;
            if (!dot_q[0]) begin
                case (state_q)
                    FETCH_NT: nt_q <= data_i;
                    FETCH_AT: at_q <= data_i[{v_i[6], v_i[1], 1'b0} +: 2];   // quadrant
                    FETCH_LO: lo_q <= data_i;
                    default: begin
                        pat_lo_q <= {pat_lo_q[14:7], lo_q};
                        pat_hi_q <= {pat_hi_q[14:7], data_i};
                        at_lo_q  <= {at_lo_q[14:7], {8{at_q[0]}}};
                        at_hi_q  <= {at_hi_q[14:7], {8{at_q[1]}}};
                    end
                endcase
            end
        end
    end

    assign fetch_o.tile         = fetch_win && (state_q == FETCH_NT);
    assign fetch_o.attr         = fetch_win && (state_q == FETCH_AT);
    assign fetch_o.chr          = fetch_win && (state_q == FETCH_LO || state_q == FETCH_HI);
    assign fetch_o.pattern_addr = {cfg_i.bg_table, nt_q, state_q == FETCH_HI, v_i[14:12]};

    assign scroll_o.incx   = fetch_win && (dot_q[2:0] == 3'd0);
    assign scroll_o.incy   = cfg_i.bg_en && render_line && (dot_q == VIS_DOTS);
    assign scroll_o.resetx = cfg_i.bg_en && render_line && (dot_q == VIS_DOTS + 9'd1);
    assign scroll_o.resety = cfg_i.bg_en && (line_q == PRE_LINE) &&
                             (dot_q >= 9'd280) && (dot_q <= 9'd304);

    // fine x picks the tap
    assign bit_sel = 4'd15 - {1'b0, cfg_i.fine_x};
    assign pix     = {pat_hi_q[bit_sel], pat_lo_q[bit_sel]};
    assign pal_grp = {at_hi_q[bit_sel], at_lo_q[bit_sel]};

    assign palette_idx_o = (cfg_i.bg_en && pix != 2'd0) ? {1'b0, pal_grp, pix} : '0;
    assign px_en_o       = (line_q < VIS_LINES) && (dot_q >= 9'd1) && (dot_q <= VIS_DOTS);

    // high from dot 1 of line 241 up to dot 1 of the pre-render line
    assign vblank_o = ((line_q == VBL_LINE) && (dot_q != '0)) ||
                      ((line_q > VBL_LINE) && (line_q < PRE_LINE)) ||
                      ((line_q == PRE_LINE) && (dot_q == '0));

endmodule

`default_nettype wire

//--- verilog/ppu_palette.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_palette
    import ppu_video_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pal_idx_t addr_i,
    input  logic     wr_i,
    input  color_t   data_i,
    output color_t   data_o
);

    color_t   mem [32];
    pal_idx_t addr;

    // sprite backdrops share the background entries
    assign addr = (addr_i[4] && addr_i[1:0] == 2'b00) ? {1'b0, addr_i[3:0]} : addr_i;

    always_ff @(posedge clk) begin
        if (wr_i) mem[addr] <= data_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_o <= '0;
        end else begin
            data_o <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/ppu.sv
`timescale 1ns/1ps
`default_nettype none

module ppu
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
#(
    parameter bit external_frame_trigger = 1'b0
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_i,
    input  logic       cpu_rw_i,
    input  cpu_addr_t  cpu_addr_i,
    input  cpu_data_t  cpu_data_i,
    output cpu_data_t  cpu_data_o,
    output logic       nmi_o,
    output vram_addr_t vram_addr_o,
    input  cpu_data_t  vram_data_i,
    output cpu_data_t  vram_data_o,
    output logic       vram_wr_o,
    output color_t     px_color_o,
    output logic       px_valid_o,
    input  logic       trigger_frame_i,
    output logic       vblank_o
);

    ppu_render_cfg_t cfg;
    ppu_vaddr_cmd_t  vcmd;
    ppu_scroll_ctl_t scroll;
    ppu_fetch_t      fetch;
    vaddr_t          v;
    logic            vpal;
    logic            pal_wr;
    pal_idx_t        palette_idx;
    pal_idx_t        pal_addr;
    color_t          pal_data;
    logic            px_en;
    logic            px_en_q;

    ppu_cpu_regs u_cpu_regs (
        .clk         (clk),
        .rst         (rst),
        .cs_i        (cs_i),
        .cpu_rw_i    (cpu_rw_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_data_i  (cpu_data_i),
        .vram_data_i (vram_data_i),
        .pal_data_i  (pal_data),
        .vpal_i      (vpal),
        .vblank_i    (vblank_o),
        .cpu_data_o  (cpu_data_o),
        .cfg_o       (cfg),
        .vcmd_o      (vcmd),
        .vram_wr_o   (vram_wr_o),
        .pal_wr_o    (pal_wr),
        .wdata_o     (vram_data_o),
        .nmi_o       (nmi_o)
    );

    ppu_vram_addr u_vram_addr (
        .clk         (clk),
        .rst         (rst),
        .vcmd_i      (vcmd),
        .scroll_i    (scroll),
        .fetch_i     (fetch),
        .v_o         (v),
        .vram_addr_o (vram_addr_o),
        .vpal_o      (vpal)
    );

    ppu_bg_render #(
        .external_frame_trigger (external_frame_trigger)
    ) u_bg_render (
        .clk             (clk),
        .rst             (rst),
        .trigger_frame_i (trigger_frame_i),
        .cfg_i           (cfg),
        .v_i             (v),
        .data_i          (vram_data_i),
        .fetch_o         (fetch),
        .scroll_o        (scroll),
        .palette_idx_o   (palette_idx),
        .px_en_o         (px_en),
        .vblank_o        (vblank_o)
    );

    // CPU owns the palette port while v points into 0x3F00
    assign pal_addr = vpal ? v[4:0] : palette_idx;

    ppu_palette u_palette (
        .clk    (clk),
        .rst    (rst),
        .addr_i (pal_addr),
        .wr_i   (pal_wr),
        .data_i (vram_data_o),
        .data_o (pal_data)
    );

    // match the registered palette read
    always_ff @(posedge clk) begin
        if (rst) begin
            px_en_q <= 1'b0;
        end else begin
            px_en_q <= px_en;
        end
    end

    assign px_valid_o = px_en_q;
    assign px_color_o = pal_data;

endmodule

`default_nettype wire

//--- dv/ppu_vram_model.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_vram_model
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
(
    input  logic       clk,
    input  vram_addr_t addr_i,
    input  logic       wr_i,
    input  cpu_data_t  data_i,
    output cpu_data_t  data_o
);

    localparam int DEPTH = 16384;

    cpu_data_t mem [DEPTH];

    // every address bit shows up in the power-up byte
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 6) ^ 8'h5A;
        end
    end

    always @(posedge clk) begin
        if (wr_i) mem[addr_i] <= data_i;
    end

    assign data_o = mem[addr_i];   // combinational read

endmodule

`default_nettype wire

//--- dv/ppu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_tb
    import ppu_reg_pkg::*;
    import ppu_video_pkg::*;
();

    localparam int  SEED         = 36105;
    localparam int  HALF_PERIOD  = 20;
    localparam int  FRAME_CYCLES = LINES_PER_FRAME * DOTS_PER_LINE;
    localparam int  BUS_CYCLES   = 3 * 2400;    // three cycles per access
    localparam int  TIMEOUT      = 3 * FRAME_CYCLES + BUS_CYCLES + 2000;
    localparam int  FRAME_PIXELS = VISIBLE_DOTS * VISIBLE_LINES;
    localparam time VBLANK_NS    = 20 * DOTS_PER_LINE * 2 * HALF_PERIOD;

    typedef struct packed {
        vram_addr_t addr;
        cpu_data_t  data;
    } vram_wr_t;

    logic       clk;
    logic       rst;
    logic       cs;
    logic       cpu_rw;
    cpu_addr_t  cpu_addr;
    cpu_data_t  cpu_wdata;
    logic       trigger_frame;
    cpu_data_t  cpu_rdata;
    logic       nmi;
    vram_addr_t vram_addr;
    cpu_data_t  vram_rdata;
    cpu_data_t  vram_wdata;
    logic       vram_wr;
    color_t     px_color;
    logic       px_valid;
    logic       vblank;

    int         mismatch_count;
    int         fault_count;
    vram_wr_t   wr_queue [$];       // data port writes still due on the VRAM bus
    cpu_data_t  shadow [int];
    color_t     exp_pal [32];
    vram_addr_t cur_addr;
    logic       inc32_exp;
    logic       nmi_en_exp;
    cpu_data_t  exp_buf;
    logic       buf_known;
    logic       count_en;
    color_t     exp_color;
    int         px_count;
    int         px_bad;

    ppu #(
        .external_frame_trigger (1'b0)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .cs_i            (cs),
        .cpu_rw_i        (cpu_rw),
        .cpu_addr_i      (cpu_addr),
        .cpu_data_i      (cpu_wdata),
        .cpu_data_o      (cpu_rdata),
        .nmi_o           (nmi),
        .vram_addr_o     (vram_addr),
        .vram_data_i     (vram_rdata),
        .vram_data_o     (vram_wdata),
        .vram_wr_o       (vram_wr),
        .px_color_o      (px_color),
        .px_valid_o      (px_valid),
        .trigger_frame_i (trigger_frame),
        .vblank_o        (vblank)
    );

    ppu_vram_model u_vram (
        .clk    (clk),
        .addr_i (vram_addr),
        .wr_i   (vram_wr),
        .data_i (vram_wdata),
        .data_o (vram_rdata)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    function automatic void note_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t ns: %s", $time, msg);
    endfunction

    function automatic void note_fault(input string msg);
        fault_count++;
        $display("error at %0t ns: %s", $time, msg);
    endfunction

    function automatic logic in_palette(input vram_addr_t addr);
        return addr[13:8] == 6'h3F;
    endfunction

    // sprite backdrop slots land on the background ones
    function automatic pal_idx_t pal_slot(input vram_addr_t addr);
        pal_idx_t idx;
        idx = addr[4:0];
        if (idx inside {5'h10, 5'h14, 5'h18, 5'h1C}) idx = idx - 5'h10;
        return idx;
    endfunction

    // cs high for two cycles and low for one
    task automatic bus_cycle(input logic rw, input cpu_addr_t addr, input cpu_data_t wdata,
                             output cpu_data_t rdata);
        cs        = 1'b1;
        cpu_rw    = rw;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge clk);
        @(negedge clk);
        rdata = cpu_rdata;   // latched until the next access
        cs    = 1'b0;
        @(negedge clk);
    endtask

    task automatic reg_write(input cpu_addr_t addr, input cpu_data_t data);
        cpu_data_t ignored;
        bus_cycle(1'b0, addr, data, ignored);
    endtask

    task automatic reg_read(input cpu_addr_t addr, output cpu_data_t data);
        bus_cycle(1'b1, addr, 8'h00, data);
    endtask

    task automatic write_ctrl(input cpu_data_t data);
        reg_write(PPUCTRL_ADDR, data);
        inc32_exp  = data[CTRL_INC32];
        nmi_en_exp = data[CTRL_NMI_EN];
    endtask

    task automatic set_addr(input vram_addr_t addr);
        reg_write(PPUADDR_ADDR, {2'b00, addr[13:8]});
        reg_write(PPUADDR_ADDR, addr[7:0]);
        cur_addr = addr;
    endtask

    task automatic advance_addr();
        cur_addr = cur_addr + (inc32_exp ? 14'd32 : 14'd1);
    endtask

    task automatic data_write(input cpu_data_t data);
        if (in_palette(cur_addr)) begin
            exp_pal[pal_slot(cur_addr)] = data;
        end else begin
            wr_queue.push_back({cur_addr, data});
            shadow[int'(cur_addr)] = data;
        end
        reg_write(PPUDATA_ADDR, data);
        advance_addr();
    endtask

    task automatic data_read_check();
        cpu_data_t got;
        reg_read(PPUDATA_ADDR, got);
        if (in_palette(cur_addr)) begin
            assert (got == exp_pal[pal_slot(cur_addr)])
                else note_mismatch($sformatf("palette read at %h gave %h, expected %h",
                                             cur_addr, got, exp_pal[pal_slot(cur_addr)]));
        end else if (buf_known) begin
            assert (got == exp_buf)
                else note_mismatch($sformatf("data read at %h gave %h, expected buffer %h",
                                             cur_addr, got, exp_buf));
        end
        // buffer takes the byte at the address before the step
        buf_known = shadow.exists(int'(cur_addr));
        if (buf_known) exp_buf = shadow[int'(cur_addr)];
        advance_addr();
    endtask

    // one frame of pixels between the vblank fall and the next rise
    task automatic count_frame(input color_t color);
        @(negedge clk);
        exp_color = color;
        px_count  = 0;
        count_en  = 1'b1;
        @(posedge vblank);
        @(negedge clk);
        count_en = 1'b0;
        assert (px_count == FRAME_PIXELS)
            else note_mismatch($sformatf("%0d valid pixels in a frame, expected %0d",
                                         px_count, FRAME_PIXELS));
    endtask

    always @(negedge clk) begin
        vram_wr_t want;
        if (!rst && vram_wr) begin
            if (wr_queue.size() == 0) begin
                note_fault("VRAM write strobe with no data port write pending");
            end else begin
                want = wr_queue.pop_front();
                assert (vram_addr == want.addr && vram_wdata == want.data)
                    else note_mismatch($sformatf("VRAM write %h <- %h, expected %h <- %h",
                                                 vram_addr, vram_wdata, want.addr, want.data));
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            assert (!(nmi && !nmi_en_exp)) else note_mismatch("nmi_o high with NMI disabled");
        end
    end

    always @(negedge clk) begin
        if (count_en && px_valid) begin
            px_count++;
            assert (px_color == exp_color) else begin
                mismatch_count++;
                if (px_bad < 8) begin
                    $display("mismatch at %0t ns: pixel %0d is %h, expected %h",
                             $time, px_count, px_color, exp_color);
                end
                px_bad++;
            end
        end
    end

    // palette range never reaches the VRAM write strobe
    assert property (@(posedge clk) disable iff (rst) vram_wr |-> vram_addr[13:8] != 6'h3F)
        else note_mismatch("VRAM write strobe inside the palette range");

    assert property (@(posedge clk) disable iff (rst) $rose(nmi) |-> vblank)
        else note_mismatch("nmi_o rose outside vblank");

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        note_fault($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT));
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        cpu_data_t data;
        color_t    bg_color;
        color_t    fg_color;
        time       vbl_start;
        void'($urandom(SEED));
        mismatch_count = 0;
        fault_count    = 0;
        rst            = 1'b1;
        cs             = 1'b0;
        cpu_rw         = 1'b1;
        cpu_addr       = '0;
        cpu_wdata      = '0;
        trigger_frame  = 1'b0;
        count_en       = 1'b0;
        exp_color      = '0;
        px_count       = 0;
        px_bad         = 0;
        cur_addr       = '0;
        inc32_exp      = 1'b0;
        nmi_en_exp     = 1'b0;
        exp_buf        = '0;
        buf_known      = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!vram_wr && !nmi && !px_valid && !vblank && cpu_rdata == 8'h00)
            else note_mismatch("outputs not idle after reset");

        // buffered reads with a step of 1
        set_addr(14'h2000);
        for (int i = 0; i < 9; i++) data_write(8'($urandom));
        set_addr(14'h2000);
        for (int i = 0; i < 9; i++) data_read_check();

        // first read at a step of 32 still returns the stale buffer
        write_ctrl(8'(1 << CTRL_INC32));
        set_addr(14'h2100);
        for (int i = 0; i < 4; i++) data_write(8'($urandom));
        set_addr(14'h2100);
        for (int i = 0; i < 5; i++) data_read_check();
        write_ctrl(8'h00);

        // palette reads come back unbuffered
        set_addr(14'h3F00);
        for (int i = 0; i < 32; i++) data_write(8'($urandom));
        set_addr(14'h3F00);
        for (int i = 0; i < 32; i++) data_read_check();
        set_addr(14'h3F10);
        data_write(8'($urandom));
        set_addr(14'h3F00);
        data_read_check();

        // status read after half an address write clears the toggle
        reg_write(PPUADDR_ADDR, 8'h3F);
        reg_read(PPUSTATUS_ADDR, data);
        set_addr(14'h2140);
        data_write(8'($urandom));

        // tile 0 solid colour 3 across nametables 0 and 1
        set_addr(14'h0000);
        for (int i = 0; i < 16; i++) data_write(8'hFF);
        set_addr(14'h2000);
        for (int i = 0; i < 2048; i++) data_write(8'h00);

        // vblank and NMI
        write_ctrl(8'(1 << CTRL_NMI_EN));
        @(posedge vblank);
        vbl_start = $time;
        @(negedge clk);
        @(negedge clk);
        assert (nmi) else note_mismatch("nmi_o low after vblank start with NMI enabled");
        reg_read(PPUSTATUS_ADDR, data);
        assert (data[7]) else note_mismatch("status bit 7 clear during vblank");
        assert (!nmi) else note_mismatch("nmi_o still high after status read");
        reg_read(PPUSTATUS_ADDR, data);
        assert (!data[7]) else note_mismatch("status bit 7 set on second read");

        // palette and scroll set up inside vblank
        bg_color = 8'($urandom);
        fg_color = 8'($urandom);
        if (fg_color == bg_color) fg_color = ~bg_color;
        set_addr(14'h3F00);
        data_write(bg_color);
        set_addr(14'h3F03);
        data_write(fg_color);
        reg_read(PPUSTATUS_ADDR, data);
        reg_write(PPUSCROLL_ADDR, 8'h00);
        reg_write(PPUSCROLL_ADDR, 8'h00);
        write_ctrl(8'h00);                          // nametable 0, NMI off
        reg_write(PPUMASK_ADDR, 8'(1 << MASK_BG_EN));

        @(negedge vblank);
        assert ($time - vbl_start == VBLANK_NS)
            else note_mismatch($sformatf("vblank lasted %0t ns", $time - vbl_start));
        count_frame(fg_color);

        // rendering off shows the backdrop entry
        reg_write(PPUMASK_ADDR, 8'h00);
        @(negedge vblank);
        count_frame(bg_color);

        if (wr_queue.size() != 0) note_fault("expected VRAM writes never appeared");
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ppu.f
verilog/ppu_reg_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_cpu_regs.sv
verilog/ppu_vram_addr.sv
verilog/ppu_bg_render.sv
verilog/ppu_palette.sv
verilog/ppu.sv
dv/ppu_vram_model.sv
dv/ppu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f ppu.f --top-module ppu_tb -o ppu_sim \
    > build.log 2>&1 \
    && ./obj_dir/ppu_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Finished with no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
